// ==== filelist.f ====
+incdir+source
source/uart_pkg.sv
source/uart_clkdiv_frac.sv
source/uart_fifo.sv
source/uart_tx.sv
source/uart_rx.sv
source/uart_regs.sv
source/uart_mini.sv
testbench/uart_tb.sv

// ==== source/uart_clkdiv_frac.sv ====
// Fractional baud divider, pulses the oversample enable for the TX and RX engines
`timescale 1ns/10ps
`default_nettype none
`include "uart_consts.svh"

module uart_clkdiv_frac (
	input  wire                  clk,
	input  wire                  rst_n_sync,
	input  wire uart_pkg::uart_ctrl_t ctrl_i,
	output logic                 clk_en_o
);

	logic [`UART_W_DIV_INT-1:0]  ctr_q;
	logic [`UART_W_DIV_FRAC-1:0] frac_q;
	logic [`UART_W_DIV_FRAC:0]   frac_sum;
	logic [`UART_W_DIV_INT-1:0]  reload;

	// Top bit of the sum is the fraction carry
	assign frac_sum = {1'b0, frac_q} + {1'b0, ctrl_i.div_frac};

	// Period is div_int, one cycle longer on a carry
	assign reload = ctrl_i.div_int -
		{{(`UART_W_DIV_INT-1){1'b0}}, ~frac_sum[`UART_W_DIV_FRAC]};

	assign clk_en_o = ctrl_i.en && (ctr_q == '0);

	always_ff @(posedge clk or negedge rst_n_sync) begin
		if (!rst_n_sync) begin
			ctr_q  <= '0;
			frac_q <= '0;
		end else if (!ctrl_i.en) begin
			ctr_q  <= '0;
			frac_q <= '0;
		end else if (ctr_q == '0) begin
			ctr_q  <= reload;
			frac_q <= frac_sum[`UART_W_DIV_FRAC-1:0];
		end else begin
			ctr_q <= ctr_q - 1'b1;
		end
	end

	a_no_pulse_disabled: assert property (@(posedge clk) disable iff (!rst_n_sync)
		!ctrl_i.en |-> !clk_en_o);

endmodule

`default_nettype wire

// ==== source/uart_consts.svh ====
// UART build constants, included by the package and by every RTL file that sizes logic from them
`ifndef UART_CONSTS_SVH
`define UART_CONSTS_SVH

// Entries per FIFO, a power of two and at least 2
`define UART_FIFO_DEPTH 4

// Oversample strobes per bit period
`define UART_OVERSAMPLE 8

// Fractional divider widths
`define UART_W_DIV_INT 10
`define UART_W_DIV_FRAC 4

// FIFO level counter, wide enough to hold the full depth
`define UART_W_LEVEL ($clog2(`UART_FIFO_DEPTH) + 1)

`endif

// ==== source/uart_fifo.sv ====
// First-word-fall-through byte FIFO, instanced once for TX and once for RX
`timescale 1ns/10ps
`default_nettype none
`include "uart_consts.svh"

module uart_fifo (
	input  wire                        clk,
	input  wire                        rst_n_sync,
	input  wire [7:0]                  wdata_i,
	input  wire                        wen_i,
	output logic [7:0]                 rdata_o,
	input  wire                        ren_i,
	output uart_pkg::uart_fifo_stat_t  stat_o
);

	localparam int W_PTR = $clog2(`UART_FIFO_DEPTH);

	logic [7:0]               mem [`UART_FIFO_DEPTH];
	logic [W_PTR-1:0]         wptr_q;
	logic [W_PTR-1:0]         rptr_q;
	logic [`UART_W_LEVEL-1:0] level_q;
	logic                     push;
	logic                     pop;

	// Push when full and pop when empty are dropped
	assign push = wen_i && !stat_o.full;
	assign pop  = ren_i && !stat_o.empty;

	assign rdata_o      = mem[rptr_q];
	assign stat_o.level = level_q;
	assign stat_o.full  = level_q == `UART_W_LEVEL'(`UART_FIFO_DEPTH);
	assign stat_o.empty = level_q == '0;

	always_ff @(posedge clk) begin
		if (push)
			mem[wptr_q] <= wdata_i;
	end

	always_ff @(posedge clk or negedge rst_n_sync) begin
		if (!rst_n_sync) begin
			wptr_q  <= '0;
			rptr_q  <= '0;
			level_q <= '0;
		end else begin
			if (push)
				wptr_q <= wptr_q + 1'b1;
			if (pop)
				rptr_q <= rptr_q + 1'b1;
			if (push && !pop)
				level_q <= level_q + 1'b1;
			else if (pop && !push)
				level_q <= level_q - 1'b1;
		end
	end

	a_level_bound: assert property (@(posedge clk) disable iff (!rst_n_sync)
		level_q <= `UART_W_LEVEL'(`UART_FIFO_DEPTH));

endmodule

`default_nettype wire

// ==== source/uart_mini.sv ====
// Top level of the minimal APB UART, instance this block and drive its APB slave port
`timescale 1ns/10ps
`default_nettype none

module uart_mini (
	input  wire         clk,
	input  wire         rst_n_sync,
	input  wire         psel_i,
	input  wire         penable_i,
	input  wire         pwrite_i,
	input  wire [15:0]  paddr_i,
	input  wire [31:0]  pwdata_i,
	output logic [31:0] prdata_o,
	output logic        pslverr_o,
	input  wire         rx_i,
	output logic        tx_o,
	input  wire         cts_i,
	output logic        rts_o,
	output logic        irq_o,
	output logic        dreq_o
);

	import uart_pkg::*;

	uart_ctrl_t      ctrl;
	uart_fifo_stat_t tx_stat;
	uart_fifo_stat_t rx_stat;
	logic            clk_en;
	logic            busy;
	logic            tx_wen;
	logic [7:0]      tx_wdata;
	logic            tx_ren;
	logic [7:0]      tx_rdata;
	logic            rx_wen;
	logic [7:0]      rx_wdata;
	logic            rx_ren;
	logic [7:0]      rx_rdata;

	// DMA request mirrors the interrupt
	assign dreq_o = irq_o;

	uart_regs u_regs (
		.clk        (clk),
		.rst_n_sync (rst_n_sync),
		.psel_i     (psel_i),
		.penable_i  (penable_i),
		.pwrite_i   (pwrite_i),
		.paddr_i    (paddr_i),
		.pwdata_i   (pwdata_i),
		.prdata_o   (prdata_o),
		.pslverr_o  (pslverr_o),
		.ctrl_o     (ctrl),
		.busy_i     (busy),
		.tx_stat_i  (tx_stat),
		.rx_stat_i  (rx_stat),
		.tx_wen_o   (tx_wen),
		.tx_wdata_o (tx_wdata),
		.tx_ren_i   (tx_ren),
		.rx_ren_o   (rx_ren),
		.rx_rdata_i (rx_rdata),
		.rx_wen_i   (rx_wen),
		.rts_o      (rts_o),
		.irq_o      (irq_o)
	);

	uart_clkdiv_frac u_clkdiv (
		.clk        (clk),
		.rst_n_sync (rst_n_sync),
		.ctrl_i     (ctrl),
		.clk_en_o   (clk_en)
	);

	// ==============================
	// Transmit path
	// ==============================

	uart_fifo u_tx_fifo (
		.clk        (clk),
		.rst_n_sync (rst_n_sync),
		.wdata_i    (tx_wdata),
		.wen_i      (tx_wen),
		.rdata_o    (tx_rdata),
		.ren_i      (tx_ren),
		.stat_o     (tx_stat)
	);

	uart_tx u_tx (
		.clk         (clk),
		.rst_n_sync  (rst_n_sync),
		.ctrl_i      (ctrl),
		.clk_en_i    (clk_en),
		.cts_i       (cts_i),
		.rts_i       (rts_o),
		.fifo_data_i (tx_rdata),
		.fifo_stat_i (tx_stat),
		.fifo_ren_o  (tx_ren),
		.tx_o        (tx_o),
		.busy_o      (busy)
	);

	// ==============================
	// Receive path
	// ==============================

	uart_rx u_rx (
		.clk          (clk),
		.rst_n_sync   (rst_n_sync),
		.ctrl_i       (ctrl),
		.clk_en_i     (clk_en),
		.rx_i         (rx_i),
		.tx_i         (tx_o),
		.fifo_wen_o   (rx_wen),
		.fifo_wdata_o (rx_wdata)
	);

	uart_fifo u_rx_fifo (
		.clk        (clk),
		.rst_n_sync (rst_n_sync),
		.wdata_i    (rx_wdata),
		.wen_i      (rx_wen),
		.rdata_o    (rx_rdata),
		.ren_i      (rx_ren),
		.stat_o     (rx_stat)
	);

endmodule

`default_nettype wire

// ==== source/uart_pkg.sv ====
// UART shared types, compiled before the RTL so modules can import the enums and structs
`default_nettype none
`include "uart_consts.svh"

package uart_pkg;

	typedef enum logic [3:0] {
		TX_IDLE, TX_START,
		TX_DATA0, TX_DATA1, TX_DATA2, TX_DATA3,
		TX_DATA4, TX_DATA5, TX_DATA6, TX_DATA7,
		TX_STOP
	} uart_tx_state_e;

	typedef enum logic [3:0] {
		RX_IDLE, RX_START,
		RX_DATA0, RX_DATA1, RX_DATA2, RX_DATA3,
		RX_DATA4, RX_DATA5, RX_DATA6, RX_DATA7,
		RX_STOP
	} uart_rx_state_e;

	// APB byte offsets of the registers
	typedef enum logic [15:0] {
		REG_CSR   = 16'h0000,
		REG_DIV   = 16'h0004,
		REG_FSTAT = 16'h0008,
		REG_TX    = 16'h000C,
		REG_RX    = 16'h0010
	} uart_reg_e;

	typedef struct packed {
		logic                        en;
		logic                        txie;
		logic                        rxie;
		logic                        ctsen;
		logic                        loopback;
		logic [`UART_W_DIV_INT-1:0]  div_int;
		logic [`UART_W_DIV_FRAC-1:0] div_frac;
	} uart_ctrl_t;

	typedef struct packed {
		logic [`UART_W_LEVEL-1:0] level;
		logic                     full;
		logic                     empty;
	} uart_fifo_stat_t;

endpackage

`default_nettype wire

// ==== source/uart_regs.sv ====
// APB register block of the UART with control, status, data ports, RTS and interrupt
`timescale 1ns/10ps
`default_nettype none
`include "uart_consts.svh"

module uart_regs (
	input  wire                        clk,
	input  wire                        rst_n_sync,
	input  wire                        psel_i,
	input  wire                        penable_i,
	input  wire                        pwrite_i,
	input  wire [15:0]                 paddr_i,
	input  wire [31:0]                 pwdata_i,
	output logic [31:0]                prdata_o,
	output logic                       pslverr_o,
	output uart_pkg::uart_ctrl_t       ctrl_o,
	input  wire                        busy_i,
	input  wire uart_pkg::uart_fifo_stat_t tx_stat_i,
	input  wire uart_pkg::uart_fifo_stat_t rx_stat_i,
	output logic                       tx_wen_o,
	output logic [7:0]                 tx_wdata_o,
	input  wire                        tx_ren_i,
	output logic                       rx_ren_o,
	input  wire [7:0]                  rx_rdata_i,
	input  wire                        rx_wen_i,
	output logic                       rts_o,
	output logic                       irq_o
);

	import uart_pkg::*;

	// Order is rx underflow, rx overflow, tx underflow, tx overflow
	logic [3:0] sticky_q;
	logic [3:0] sticky_set;
	logic [3:0] sticky_clr;
	logic       acc;
	logic       wr;

	// One FSTAT half, same layout for TX and RX
	function automatic logic [15:0] fstat_half(uart_fifo_stat_t s, logic ovf, logic unf);
		return {4'h0, unf, ovf, s.empty, s.full, 8'(s.level)};
	endfunction

	assign acc        = psel_i && penable_i;
	assign wr         = acc && pwrite_i;
	assign tx_wen_o   = wr && (paddr_i == REG_TX);
	assign tx_wdata_o = pwdata_i[7:0];
	assign rx_ren_o   = acc && !pwrite_i && (paddr_i == REG_RX);

	assign irq_o = (ctrl_o.txie && !tx_stat_i.full) || (ctrl_o.rxie && !rx_stat_i.empty);

	assign sticky_set = {
		rx_ren_o && rx_stat_i.empty,
		rx_wen_i && rx_stat_i.full,
		tx_ren_i && tx_stat_i.empty,
		tx_wen_o && tx_stat_i.full
	};
	assign sticky_clr = (wr && paddr_i == REG_FSTAT) ?
		{pwdata_i[27:26], pwdata_i[11:10]} : 4'h0;

	always_comb begin
		prdata_o  = '0;
		pslverr_o = 1'b0;
		if (acc) begin
			case (paddr_i)
				REG_CSR: prdata_o = {26'h0, ctrl_o.loopback, ctrl_o.ctsen,
					ctrl_o.rxie, ctrl_o.txie, busy_i, ctrl_o.en};
				REG_DIV: prdata_o = {18'h0, ctrl_o.div_int, ctrl_o.div_frac};
				REG_FSTAT: prdata_o = {fstat_half(rx_stat_i, sticky_q[2], sticky_q[3]),
					fstat_half(tx_stat_i, sticky_q[0], sticky_q[1])};
				REG_TX: prdata_o = '0;
				REG_RX: prdata_o = {24'h0, rx_rdata_i};
				default: pslverr_o = 1'b1;
			endcase
		end
	end

	always_ff @(posedge clk or negedge rst_n_sync) begin
		if (!rst_n_sync) begin
			ctrl_o   <= '0;
			sticky_q <= '0;
			rts_o    <= 1'b1;
		end else begin
			// Hardware set wins over a clear in the same cycle
			sticky_q <= (sticky_q & ~sticky_clr) | sticky_set;
			rts_o    <= rx_stat_i.level > (`UART_FIFO_DEPTH - 2);
			if (wr && paddr_i == REG_CSR) begin
				ctrl_o.en       <= pwdata_i[0];
				ctrl_o.txie     <= pwdata_i[2];
				ctrl_o.rxie     <= pwdata_i[3];
				ctrl_o.ctsen    <= pwdata_i[4];
				ctrl_o.loopback <= pwdata_i[5];
			end
			if (wr && paddr_i == REG_DIV) begin
				ctrl_o.div_frac <= pwdata_i[3:0];
				ctrl_o.div_int  <= pwdata_i[13:4];
			end
		end
	end

	// An accepted TX write is visible in the FIFO status on the next cycle
	a_tx_push_lands: assert property (@(posedge clk) disable iff (!rst_n_sync)
		tx_wen_o && !tx_stat_i.full |=> !tx_stat_i.empty);

endmodule

`default_nettype wire

// ==== source/uart_rx.sv ====
// UART receiver, filters the line and pushes frames with a valid stop bit into the RX FIFO
`timescale 1ns/10ps
`default_nettype none
`include "uart_consts.svh"

module uart_rx (
	input  wire                        clk,
	input  wire                        rst_n_sync,
	input  wire uart_pkg::uart_ctrl_t  ctrl_i,
	input  wire                        clk_en_i,
	input  wire                        rx_i,
	input  wire                        tx_i,
	output logic                       fifo_wen_o,
	output logic [7:0]                 fifo_wdata_o
);

	import uart_pkg::*;

	localparam int W_OVER = $clog2(`UART_OVERSAMPLE);

	uart_rx_state_e    state_q;
	logic [W_OVER-1:0] over_q;
	logic [7:0]        shifter_q;
	logic [1:0]        din_prev_q;
	logic              din_q;
	logic              din_raw;
	logic              bit_tick;

	assign din_raw      = ctrl_i.loopback ? tx_i : rx_i;
	assign bit_tick     = clk_en_i && (over_q == '0);
	assign fifo_wdata_o = shifter_q;

	// ==============================
	// Glitch filter
	// ==============================

	always_ff @(posedge clk or negedge rst_n_sync) begin
		if (!rst_n_sync) begin
			din_prev_q <= 2'b11;
			din_q      <= 1'b1;
		end else begin
			din_prev_q <= {din_prev_q[0], din_raw};
			if (&{din_prev_q, din_raw})
				din_q <= 1'b1;
			else if (~|{din_prev_q, din_raw})
				din_q <= 1'b0;
		end
	end

	// ==============================
	// Frame state machine
	// ==============================

	always_ff @(posedge clk) begin
		if (bit_tick && state_q >= RX_DATA0 && state_q <= RX_DATA7)
			shifter_q <= {din_q, shifter_q[7:1]};
	end

	always_ff @(posedge clk or negedge rst_n_sync) begin
		if (!rst_n_sync) begin
			state_q    <= RX_IDLE;
			over_q     <= '0;
			fifo_wen_o <= 1'b0;
		end else if (!ctrl_i.en) begin
			state_q    <= RX_IDLE;
			over_q     <= '0;
			fifo_wen_o <= 1'b0;
		end else begin
			fifo_wen_o <= 1'b0;
			if (clk_en_i)
				over_q <= over_q + 1'b1;
			if (bit_tick) begin
				case (state_q)
					RX_IDLE: begin
						if (din_q) begin
							over_q <= '0;
						end else begin
							// Half a bit to the middle of the start bit
							state_q <= RX_START;
							over_q  <= W_OVER'(`UART_OVERSAMPLE / 2);
						end
					end
					RX_START: begin
						// A start bit that is gone by mid-bit was a glitch
						state_q <= din_q ? RX_IDLE : RX_DATA0;
					end
					RX_STOP: begin
						fifo_wen_o <= din_q;
						state_q    <= RX_IDLE;
						over_q     <= '0;
					end
					default: begin
						state_q <= uart_rx_state_e'(state_q + 4'd1);
					end
				endcase
			end
		end
	end

endmodule

`default_nettype wire

// ==== source/uart_tx.sv ====
// UART transmitter, serializes bytes from the TX FIFO onto tx with CTS flow control
`timescale 1ns/10ps
`default_nettype none
`include "uart_consts.svh"

module uart_tx (
	input  wire                        clk,
	input  wire                        rst_n_sync,
	input  wire uart_pkg::uart_ctrl_t  ctrl_i,
	input  wire                        clk_en_i,
	input  wire                        cts_i,
	input  wire                        rts_i,
	input  wire [7:0]                  fifo_data_i,
	input  wire uart_pkg::uart_fifo_stat_t fifo_stat_i,
	output logic                       fifo_ren_o,
	output logic                       tx_o,
	output logic                       busy_o
);

	import uart_pkg::*;

	localparam int W_OVER = $clog2(`UART_OVERSAMPLE);

	uart_tx_state_e    state_q;
	logic [W_OVER-1:0] over_q;
	logic [7:0]        shifter_q;
	logic              bit_tick;
	logic              cts_sel;
	logic              hold;

	// Loopback routes our own RTS back as CTS
	assign cts_sel  = ctrl_i.loopback ? rts_i : cts_i;
	assign hold     = fifo_stat_i.empty || (ctrl_i.ctsen && cts_sel);
	assign bit_tick = clk_en_i && (over_q == '0);
	assign busy_o   = (state_q != TX_IDLE) || !fifo_stat_i.empty;

	// Frames start only from idle or at the end of a stop bit
	assign fifo_ren_o = bit_tick && !hold && (state_q == TX_IDLE || state_q == TX_STOP);

	always_ff @(posedge clk) begin
		if (fifo_ren_o)
			shifter_q <= fifo_data_i;
		else if (bit_tick && state_q != TX_IDLE && state_q != TX_STOP)
			shifter_q <= shifter_q >> 1;
	end

	always_ff @(posedge clk or negedge rst_n_sync) begin
		if (!rst_n_sync) begin
			state_q <= TX_IDLE;
			over_q  <= '0;
			tx_o    <= 1'b1;
		end else if (!ctrl_i.en) begin
			state_q <= TX_IDLE;
			over_q  <= '0;
			tx_o    <= 1'b1;
		end else begin
			if (clk_en_i)
				over_q <= over_q + 1'b1;
			if (bit_tick) begin
				case (state_q)
					TX_IDLE, TX_STOP: begin
						if (hold) begin
							// Park with the counter at zero so a new byte starts at once
							state_q <= TX_IDLE;
							over_q  <= '0;
						end else begin
							state_q <= TX_START;
							tx_o    <= 1'b0;
						end
					end
					TX_START: begin
						state_q <= TX_DATA0;
						tx_o    <= shifter_q[0];
					end
					TX_DATA7: begin
						state_q <= TX_STOP;
						tx_o    <= 1'b1;
					end
					default: begin
						state_q <= uart_tx_state_e'(state_q + 4'd1);
						tx_o    <= shifter_q[0];
					end
				endcase
			end
		end
	end

	a_pop_not_empty: assert property (@(posedge clk) disable iff (!rst_n_sync)
		fifo_ren_o |-> !fifo_stat_i.empty);

endmodule

`default_nettype wire

// ==== testbench/uart_tb.sv ====
// Self-checking testbench for the APB UART, compiled from filelist.f with uart_tb as the top
`timescale 1ns/10ps
`default_nettype none
`include "uart_consts.svh"

module uart_tb;

	import uart_pkg::*;

	// Poll and edge-search limit for every wait loop
	localparam int WAIT_LIMIT = 2000;

	logic        clk = 1'b0;
	logic        rst_n_sync;
	logic        psel;
	logic        penable;
	logic        pwrite;
	logic [15:0] paddr;
	logic [31:0] pwdata;
	logic [31:0] prdata;
	logic        pslverr;
	logic        rx;
	logic        tx;
	logic        cts;
	logic        rts;
	logic        irq;
	logic        dreq;

	integer      seed = 54;
	int          errors = 0;
	int          checks = 0;
	logic [7:0]  model[$];

	uart_mini u_dut (
		.clk        (clk),
		.rst_n_sync (rst_n_sync),
		.psel_i     (psel),
		.penable_i  (penable),
		.pwrite_i   (pwrite),
		.paddr_i    (paddr),
		.pwdata_i   (pwdata),
		.prdata_o   (prdata),
		.pslverr_o  (pslverr),
		.rx_i       (rx),
		.tx_o       (tx),
		.cts_i      (cts),
		.rts_o      (rts),
		.irq_o      (irq),
		.dreq_o     (dreq)
	);

	always #50 clk = ~clk;

	// ==============================
	// APB access and compare helpers
	// ==============================

	task automatic write_reg(input logic [15:0] addr, input logic [31:0] data);
		@(posedge clk);
		psel    <= 1'b1;
		penable <= 1'b0;
		pwrite  <= 1'b1;
		paddr   <= addr;
		pwdata  <= data;
		@(posedge clk);
		penable <= 1'b1;
		@(posedge clk);
		psel    <= 1'b0;
		penable <= 1'b0;
		pwrite  <= 1'b0;
	endtask

	task automatic read_reg(input logic [15:0] addr, output logic [31:0] data,
		output logic err);
		@(posedge clk);
		psel    <= 1'b1;
		penable <= 1'b0;
		pwrite  <= 1'b0;
		paddr   <= addr;
		@(posedge clk);
		penable <= 1'b1;
		// Access phase, read data is combinational here
		@(negedge clk);
		data = prdata;
		err  = pslverr;
		@(posedge clk);
		psel    <= 1'b0;
		penable <= 1'b0;
	endtask

	task automatic byte_check(input string name, input logic [7:0] got, input logic [7:0] exp);
		checks++;
		if (got !== exp) begin
			errors++;
			$display("Error: %s = 0x%h, expected 0x%h", name, got, exp);
		end
	endtask

	task automatic bit_check(input string name, input logic got, input logic exp);
		checks++;
		if (got !== exp) begin
			errors++;
			$display("Error: %s = 0x%h, expected 0x%h", name, got, exp);
		end
	endtask

	task automatic word_check(input string name, input logic [31:0] got,
		input logic [31:0] exp);
		checks++;
		if (got !== exp) begin
			errors++;
			$display("Error: %s = 0x%h, expected 0x%h", name, got, exp);
		end
	endtask

	task automatic stat_check(input string name, input uart_fifo_stat_t got,
		input uart_fifo_stat_t exp);
		checks++;
		if (got !== exp) begin
			errors++;
			$display("Error: %s = 0x%h, expected 0x%h", name, got, exp);
		end
	endtask

	task automatic note_timeout(input string what);
		errors++;
		$display("Timeout while waiting for %s", what);
	endtask

	function automatic uart_fifo_stat_t expected_stat(input int level);
		uart_fifo_stat_t s;
		s.level = `UART_W_LEVEL'(level);
		s.full  = (level == `UART_FIFO_DEPTH);
		s.empty = (level == 0);
		return s;
	endfunction

	function automatic uart_fifo_stat_t decode_stat(input logic [15:0] half);
		uart_fifo_stat_t s;
		s.level = half[`UART_W_LEVEL-1:0];
		s.full  = half[8];
		s.empty = half[9];
		return s;
	endfunction

	// One FSTAT half from a FIFO level and its two sticky flags
	function automatic logic [15:0] fstat_half(input int level, input logic ovf, input logic unf);
		logic [15:0] h;
		h     = 16'(level & 8'hFF);
		h[8]  = (level == `UART_FIFO_DEPTH);
		h[9]  = (level == 0);
		h[10] = ovf;
		h[11] = unf;
		return h;
	endfunction

	// ==============================
	// Line-level helpers
	// ==============================

	// Finds the start bit, then samples every bit near its middle
	task automatic catch_tx_frame();
		logic [7:0] data;
		logic       start_bit;
		logic       stop_bit;
		logic [7:0] exp;
		int         n;
		n   = 0;
		exp = model.pop_front();
		while (tx && n < WAIT_LIMIT) begin
			@(negedge clk);
			n++;
		end
		if (tx) begin
			note_timeout("a start bit on tx");
		end else begin
			repeat (8) @(negedge clk);
			start_bit = tx;
			for (int i = 0; i < 8; i++) begin
				repeat (16) @(negedge clk);
				data[i] = tx;
			end
			repeat (16) @(negedge clk);
			stop_bit = tx;
			bit_check("tx start bit", start_bit, 1'b0);
			byte_check("tx data", data, exp);
			bit_check("tx stop bit", stop_bit, 1'b1);
		end
	endtask

	task automatic drive_rx_frame(input logic [7:0] data, input logic stop);
		logic [9:0] frame;
		frame = {stop, data, 1'b0};
		for (int i = 0; i < 10; i++) begin
			@(posedge clk);
			rx <= frame[i];
			repeat (15) @(posedge clk);
		end
		@(posedge clk);
		rx <= 1'b1;
		// Two idle bit times
		repeat (32) @(posedge clk);
	endtask

	task automatic wait_rx_level(input int level);
		logic [31:0]     rd;
		logic            err;
		uart_fifo_stat_t st;
		int              n;
		n = 0;
		read_reg(REG_FSTAT, rd, err);
		st = decode_stat(rd[31:16]);
		while (st.level != level && n < WAIT_LIMIT) begin
			read_reg(REG_FSTAT, rd, err);
			st = decode_stat(rd[31:16]);
			n++;
		end
		if (st.level != level)
			note_timeout("the RX FIFO level");
		else
			stat_check("rx fifo status", st, expected_stat(level));
	endtask

	// ==============================
	// Test sequence
	// ==============================

	initial begin
		logic [31:0] rd;
		logic        err;
		logic [31:0] val;
		logic [7:0]  b;

		rst_n_sync = 1'b0;
		psel       = 1'b0;
		penable    = 1'b0;
		pwrite     = 1'b0;
		paddr      = '0;
		pwdata     = '0;
		rx         = 1'b1;
		cts        = 1'b0;
		repeat (2) @(posedge clk);
		rst_n_sync <= 1'b1;

		// Reset values
		@(negedge clk);
		bit_check("tx", tx, 1'b1);
		bit_check("irq", irq, 1'b0);
		bit_check("rts", rts, 1'b1);
		@(negedge clk);
		bit_check("rts", rts, 1'b0);
		read_reg(REG_CSR, rd, err);
		word_check("csr", rd, 32'h0);
		bit_check("pslverr", err, 1'b0);
		read_reg(REG_DIV, rd, err);
		word_check("div", rd, 32'h0);
		read_reg(REG_FSTAT, rd, err);
		word_check("fstat", rd, {fstat_half(0, 1'b0, 1'b0), fstat_half(0, 1'b0, 1'b0)});
		read_reg(16'h0014, rd, err);
		word_check("prdata", rd, 32'h0);
		bit_check("pslverr", err, 1'b1);

		// Register readback, busy stays low with both FIFOs empty
		for (int i = 0; i < 4; i++) begin
			val = $random(seed) & 32'h3FFF;
			write_reg(REG_DIV, val);
			read_reg(REG_DIV, rd, err);
			word_check("div", rd, val);
			val = $random(seed) & 32'h3D;
			write_reg(REG_CSR, val);
			read_reg(REG_CSR, rd, err);
			word_check("csr", rd, val);
		end

		// Strobe every 2 cycles, so one bit is 16 cycles
		write_reg(REG_CSR, 32'h0);
		write_reg(REG_DIV, 32'h20);

		// TX serialization, bytes queued while disabled
		for (int r = 0; r < 2; r++) begin
			for (int k = 0; k < `UART_FIFO_DEPTH; k++) begin
				b = 8'($random(seed));
				model.push_back(b);
				write_reg(REG_TX, {24'h0, b});
			end
			read_reg(REG_CSR, rd, err);
			word_check("csr", rd, 32'h2);
			write_reg(REG_CSR, 32'h1);
			for (int k = 0; k < `UART_FIFO_DEPTH; k++)
				catch_tx_frame();
			read_reg(REG_FSTAT, rd, err);
			stat_check("tx fifo status", decode_stat(rd[15:0]), expected_stat(0));
			write_reg(REG_CSR, 32'h0);
		end

		// RX reception, the third frame has a bad stop bit
		write_reg(REG_CSR, 32'h1);
		for (int i = 0; i < 5; i++) begin
			b = 8'($random(seed));
			if (i == 2) begin
				drive_rx_frame(b, 1'b0);
				read_reg(REG_FSTAT, rd, err);
				stat_check("rx fifo status", decode_stat(rd[31:16]),
					expected_stat(model.size()));
			end else begin
				drive_rx_frame(b, 1'b1);
				model.push_back(b);
				wait_rx_level(model.size());
			end
		end
		while (model.size() > 0) begin
			read_reg(REG_RX, rd, err);
			byte_check("rx data", rd[7:0], model.pop_front());
		end

		// Loopback with the RX interrupt enabled
		write_reg(REG_CSR, 32'h29);
		@(negedge clk);
		bit_check("irq", irq, 1'b0);
		bit_check("dreq", dreq, 1'b0);
		for (int k = 0; k < 3; k++) begin
			b = 8'($random(seed));
			model.push_back(b);
			write_reg(REG_TX, {24'h0, b});
		end
		wait_rx_level(3);
		@(negedge clk);
		bit_check("irq", irq, 1'b1);
		bit_check("dreq", dreq, 1'b1);
		bit_check("rts", rts, 1'b1);
		while (model.size() > 0) begin
			read_reg(REG_RX, rd, err);
			byte_check("rx data", rd[7:0], model.pop_front());
		end
		repeat (2) @(negedge clk);
		bit_check("irq", irq, 1'b0);
		bit_check("dreq", dreq, 1'b0);
		bit_check("rts", rts, 1'b0);

		// Sticky flags with the UART disabled and the TX interrupt on
		write_reg(REG_CSR, 32'h04);
		@(negedge clk);
		bit_check("irq", irq, 1'b1);
		for (int k = 0; k <= `UART_FIFO_DEPTH; k++)
			write_reg(REG_TX, {24'h0, 8'($random(seed))});
		@(negedge clk);
		bit_check("irq", irq, 1'b0);
		read_reg(REG_FSTAT, rd, err);
		stat_check("tx fifo status", decode_stat(rd[15:0]), expected_stat(`UART_FIFO_DEPTH));
		word_check("fstat", rd,
			{fstat_half(0, 1'b0, 1'b0), fstat_half(`UART_FIFO_DEPTH, 1'b1, 1'b0)});
		read_reg(REG_RX, rd, err);
		bit_check("pslverr", err, 1'b0);
		read_reg(REG_FSTAT, rd, err);
		word_check("fstat", rd,
			{fstat_half(0, 1'b0, 1'b1), fstat_half(`UART_FIFO_DEPTH, 1'b1, 1'b0)});
		write_reg(REG_FSTAT, 32'h0800_0400);
		read_reg(REG_FSTAT, rd, err);
		word_check("fstat", rd,
			{fstat_half(0, 1'b0, 1'b0), fstat_half(`UART_FIFO_DEPTH, 1'b0, 1'b0)});

		$display("Checks run: %0d, errors: %0d", checks, errors);
		if (errors == 0)
			$display("Verification passed");
		else
			$display("Verification failed");
		$finish;
	end

endmodule

`default_nettype wire
